// File: src/dsp_settings.svh
/*
 * Shared widths and constants of the audio DSP core
 * Sample and word widths, memory depth, opcode field and start address
 */
`ifndef DSP_SETTINGS_SVH
`define DSP_SETTINGS_SVH

// Audio side
`define DSP_SAMPLE_W	16	// ADC/DAC sample
`define DSP_WORD_W		18	// CPU data and instruction word

// Instruction format
`define DSP_ADDR_W		12	// Address field
`define DSP_OPC_W		6	// Opcode field
`define DSP_OPC_LSB		`DSP_ADDR_W	// Opcode sits above the address

// Program/data memory
`define DSP_MEM_AW		8	// Address bits decoded by the RAM
`define DSP_MEM_DEPTH	256

// Arithmetic
`define DSP_FRAC_LSB	16	// Lowest product bit kept by MULT
`define DSP_SHL_W		3	// SHL shift count bits

`define DSP_START_PC	12'h000	// Every run starts here

`endif

// File: src/audio_pkg.sv
/*
 * Audio sample types
 * ADC/DAC sample and widened 2.16 word
 */
`include "dsp_settings.svh"

package audio_pkg;

	// Sample as seen at the top-level pins
	typedef logic signed [`DSP_SAMPLE_W-1:0] audio_sample_t;

	// Widened sample or filter result in 2.16 format
	// Two zero bits below the 16-bit sample
	typedef logic signed [`DSP_WORD_W-1:0] audio_word_t;

endpackage

// File: src/cpu_pkg.sv
/*
 * Accumulator CPU types
 * Word and address vectors, opcode enum, FSM state enum
 */
`include "dsp_settings.svh"

package cpu_pkg;

	typedef logic [`DSP_WORD_W-1:0] cpu_word_t;	// Instruction or data
	typedef logic [`DSP_ADDR_W-1:0] cpu_addr_t;	// Instruction address field
	typedef logic [`DSP_MEM_AW-1:0] mem_addr_t;	// RAM address

	// ISA opcodes
	typedef enum logic [`DSP_OPC_W-1:0] {
		OP_ADD	= 6'd0,
		OP_ST	= 6'd1,
		OP_LD	= 6'd2,
		OP_JMP	= 6'd3,
		OP_JNEG	= 6'd4,	// Branch on accumulator sign
		OP_OUT	= 6'd5,	// Ends the run
		OP_IN	= 6'd6,	// Loads the captured sample
		OP_MULT	= 6'd7,	// 2.16 fractional
		OP_SHL	= 6'd8
	} cpu_opcode_e;

	// CPU FSM
	typedef enum logic [3:0] {
		S_IDLE,		// Waiting for req
		S_FETCH,
		S_DECODE,
		S_ADD,
		S_STORE,	// Write cycle
		S_STORE2,
		S_STORE3,
		S_LOAD,
		S_JMP,
		S_JNEG,
		S_OUT,
		S_IN,
		S_MULT,
		S_SHL,
		S_RELEASE	// Holding ack until req drops
	} cpu_state_e;

endpackage

// File: src/sample_if.sv
/*
 * Framer to CPU link
 * Four-phase req/ack with sample and result words
 */
`timescale 1ns/1ps
`include "dsp_settings.svh"

interface sample_if;

	logic						req;	// Run request from framer
	logic						ack;	// Run done from CPU
	audio_pkg::audio_word_t		sample;	// Stable while req is high
	audio_pkg::audio_word_t		result;	// Valid with ack

	modport framer
	(
		output req, sample,
		input ack, result
	);

	modport cpu
	(
		input req, sample,
		output ack, result
	);

endinterface

// File: src/mem_if.sv
/*
 * CPU to program/data RAM bus
 * Address, write data, write enable and async read data
 */
`timescale 1ns/1ps
`include "dsp_settings.svh"

interface mem_if;

	cpu_pkg::cpu_addr_t		addr;	// Full 12-bit field
	cpu_pkg::cpu_word_t		wdata;	// Accumulator
	logic					we;
	cpu_pkg::cpu_word_t		rdata;	// Combinational from addr

	modport cpu
	(
		output addr, wdata, we,
		input rdata
	);

	modport memory
	(
		input addr, wdata, we,
		output rdata
	);

endinterface

// File: src/sample_framer.sv
/*
 * Sample framer
 * LR clock edge qualifier, sample capture, req sequencing, output latch
 */
`timescale 1ns/1ps
`include "dsp_settings.svh"

module sample_framer
(
	input	logic						AUD_CTRL_CLK,
	input	logic						reset,
	input	logic						dac_lrck,
	input	audio_pkg::audio_sample_t	adc_sample,
	sample_if.framer					link,
	output	audio_pkg::audio_sample_t	audio_out
);

	logic lrck_q1, lrck_q2;		// LR clock history
	logic lr_edge;				// Qualified rising edge
	logic req_q;
	logic in_flight;			// Run not yet fully retired
	audio_pkg::audio_word_t sample_q;
	audio_pkg::audio_word_t last_result;

	// Rise after two low samples
	assign lr_edge = dac_lrck && !lrck_q1 && !lrck_q2;

	// Busy from req rise until ack has dropped again
	assign in_flight = req_q || link.ack;

	////////////////////
	// Handshake and output
	////////////////////
	always_ff @(posedge AUD_CTRL_CLK or posedge reset)
	begin
		if (reset)
		begin
			lrck_q1		<= 1'b0;
			lrck_q2		<= 1'b0;
			req_q		<= 1'b0;
			last_result	<= '0;
			audio_out	<= '0;
		end
		else
		begin
			lrck_q1 <= dac_lrck;
			lrck_q2 <= lrck_q1;
			if (lr_edge)
				audio_out <= last_result[`DSP_WORD_W-1 -: `DSP_SAMPLE_W];	// Drop 2 fraction LSBs
			if (lr_edge && !in_flight)
				req_q <= 1'b1;				// New run from next cycle
			else if (req_q && link.ack)
			begin
				req_q		<= 1'b0;		// Phase 2 of handshake
				last_result	<= link.result;
			end
		end
	end

	// Capture and widen, skipped while a run is in flight
	always_ff @(posedge AUD_CTRL_CLK)
	begin
		if (lr_edge && !in_flight)
			sample_q <= {adc_sample, {(`DSP_WORD_W-`DSP_SAMPLE_W){1'b0}}};
	end

	assign link.req		= req_q;
	assign link.sample	= sample_q;	// Held for the whole run

endmodule

// File: src/sc_memory.sv
/*
 * Program/data RAM
 * 256 x 18 single port, async read, external load port
 */
`timescale 1ns/1ps
`include "dsp_settings.svh"

module sc_memory
(
	input	logic					AUD_CTRL_CLK,
	mem_if.memory					bus,
	input	logic					prog_we,
	input	cpu_pkg::mem_addr_t		prog_addr,
	input	cpu_pkg::cpu_word_t		prog_data
);

	cpu_pkg::cpu_word_t ram [`DSP_MEM_DEPTH];
	cpu_pkg::mem_addr_t cpu_addr;

	// Upper address bits are not decoded
	assign cpu_addr = bus.addr[`DSP_MEM_AW-1:0];

	// Single write port
	always_ff @(posedge AUD_CTRL_CLK)
	begin
		if (prog_we)
			ram[prog_addr] <= prog_data;	// Loader wins
		else if (bus.we)
			ram[cpu_addr] <= bus.wdata;		// CPU store
	end

	// Combinational read at CPU address
	assign bus.rdata = ram[cpu_addr];

endmodule

// File: src/sc_cpu.sv
/*
 * 18-bit accumulator CPU
 * Fetch/decode/execute FSM, 2.16 fractional multiply, req/ack run control
 */
`timescale 1ns/1ps
`include "dsp_settings.svh"

module sc_cpu
(
	input	logic	AUD_CTRL_CLK,
	input	logic	reset,
	sample_if.cpu	link,
	mem_if.cpu		bus
);

	cpu_pkg::cpu_state_e state;
	cpu_pkg::cpu_addr_t pc;
	cpu_pkg::cpu_word_t acc;		// Accumulator
	cpu_pkg::cpu_word_t ir;			// Instruction register
	cpu_pkg::cpu_word_t mdr;		// Operand latched in DECODE
	cpu_pkg::cpu_word_t result_q;
	cpu_pkg::cpu_addr_t ir_addr;
	cpu_pkg::cpu_opcode_e opcode;
	logic ack_q;
	logic acc_neg;
	logic signed [2*`DSP_WORD_W-1:0] product;
	cpu_pkg::cpu_word_t mult_res;

	assign ir_addr	= ir[`DSP_ADDR_W-1:0];
	assign opcode	= cpu_pkg::cpu_opcode_e'(ir[`DSP_WORD_W-1:`DSP_OPC_LSB]);
	assign acc_neg	= acc[`DSP_WORD_W-1];

	////////////////////
	// Fractional multiply
	////////////////////
	assign product = $signed(acc) * $signed(mdr);
	// Sign plus bits 32..16 of the product
	assign mult_res = {product[2*`DSP_WORD_W-1],
		product[`DSP_FRAC_LSB+`DSP_WORD_W-2:`DSP_FRAC_LSB]};

	////////////////////
	// Main FSM
	////////////////////
	always_ff @(posedge AUD_CTRL_CLK or posedge reset)
	begin
		if (reset)
		begin
			state	<= cpu_pkg::S_IDLE;
			pc		<= `DSP_START_PC;
			ack_q	<= 1'b0;
		end
		else
		begin
			case (state)
				cpu_pkg::S_IDLE:
				begin
					if (link.req)
					begin
						pc		<= `DSP_START_PC;	// Fresh run
						acc		<= '0;
						state	<= cpu_pkg::S_FETCH;
					end
				end
				cpu_pkg::S_FETCH:
				begin
					ir		<= bus.rdata;
					pc		<= pc + 1'b1;
					state	<= cpu_pkg::S_DECODE;
				end
				cpu_pkg::S_DECODE:
				begin
					mdr <= bus.rdata;	// Operand at address field
					case (opcode)
						cpu_pkg::OP_ADD:	state <= cpu_pkg::S_ADD;
						cpu_pkg::OP_ST:		state <= cpu_pkg::S_STORE;
						cpu_pkg::OP_LD:		state <= cpu_pkg::S_LOAD;
						cpu_pkg::OP_JMP:	state <= cpu_pkg::S_JMP;
						cpu_pkg::OP_JNEG:	state <= cpu_pkg::S_JNEG;
						cpu_pkg::OP_OUT:	state <= cpu_pkg::S_OUT;
						cpu_pkg::OP_IN:		state <= cpu_pkg::S_IN;
						cpu_pkg::OP_MULT:	state <= cpu_pkg::S_MULT;
						cpu_pkg::OP_SHL:	state <= cpu_pkg::S_SHL;
						default:			state <= cpu_pkg::S_FETCH;	// Unknown opcode
					endcase
				end
				cpu_pkg::S_ADD:
				begin
					acc		<= acc + mdr;	// Wraps at 18 bits
					state	<= cpu_pkg::S_FETCH;
				end
				cpu_pkg::S_STORE:	state <= cpu_pkg::S_STORE2;	// we high here
				cpu_pkg::S_STORE2:	state <= cpu_pkg::S_STORE3;
				cpu_pkg::S_STORE3:	state <= cpu_pkg::S_FETCH;
				cpu_pkg::S_LOAD:
				begin
					acc		<= mdr;
					state	<= cpu_pkg::S_FETCH;
				end
				cpu_pkg::S_JMP:
				begin
					pc		<= ir_addr;
					state	<= cpu_pkg::S_FETCH;
				end
				cpu_pkg::S_JNEG:
				begin
					if (acc_neg)
						pc <= ir_addr;	// Taken
					state <= cpu_pkg::S_FETCH;
				end
				cpu_pkg::S_IN:
				begin
					acc		<= link.sample;
					state	<= cpu_pkg::S_FETCH;
				end
				cpu_pkg::S_MULT:
				begin
					acc		<= mult_res;
					state	<= cpu_pkg::S_FETCH;
				end
				cpu_pkg::S_SHL:
				begin
					acc		<= acc << mdr[`DSP_SHL_W-1:0];
					state	<= cpu_pkg::S_FETCH;
				end
				cpu_pkg::S_OUT:
				begin
					result_q	<= acc;
					ack_q		<= 1'b1;	// Run done
					state		<= cpu_pkg::S_RELEASE;
				end
				cpu_pkg::S_RELEASE:
				begin
					// Hold ack until framer drops req
					if (!link.req)
					begin
						ack_q	<= 1'b0;
						state	<= cpu_pkg::S_IDLE;
					end
				end
				default:	state <= cpu_pkg::S_FETCH;
			endcase
		end
	end

	////////////////////
	// Memory address and write
	////////////////////
	always_comb
	begin
		case (state)
			cpu_pkg::S_IDLE:	bus.addr = `DSP_START_PC;
			cpu_pkg::S_DECODE,
			cpu_pkg::S_STORE,
			cpu_pkg::S_JMP:		bus.addr = ir_addr;
			cpu_pkg::S_JNEG:	bus.addr = acc_neg ? ir_addr : pc;
			default:			bus.addr = pc;
		endcase
	end

	assign bus.we		= (state == cpu_pkg::S_STORE);	// First store cycle only
	assign bus.wdata	= acc;

	assign link.ack		= ack_q;
	assign link.result	= result_q;

endmodule

// File: src/dsp_core_top.sv
/*
 * Audio DSP core top level
 * Framer, program RAM and CPU joined by the handshake and memory links
 */
`timescale 1ns/1ps
`include "dsp_settings.svh"

module dsp_core_top
(
	input	logic						AUD_CTRL_CLK,
	input	logic						reset,
	input	logic						dac_lrck,		// DAC LR clock
	input	audio_pkg::audio_sample_t	adc_sample,
	input	logic						prog_we,		// Load port
	input	cpu_pkg::mem_addr_t			prog_addr,
	input	cpu_pkg::cpu_word_t			prog_data,
	output	audio_pkg::audio_sample_t	audio_out		// Mono result
);

	sample_if link_i ();	// Framer to CPU
	mem_if bus_i ();		// CPU to RAM

	////////////////////
	// Sample framing
	////////////////////
	sample_framer sample_framer_i
	(
		.AUD_CTRL_CLK	(AUD_CTRL_CLK),
		.reset			(reset),
		.dac_lrck		(dac_lrck),
		.adc_sample		(adc_sample),
		.link			(link_i.framer),
		.audio_out		(audio_out)
	);

	// Program and data store
	sc_memory sc_memory_i
	(
		.AUD_CTRL_CLK	(AUD_CTRL_CLK),
		.bus			(bus_i.memory),
		.prog_we		(prog_we),
		.prog_addr		(prog_addr),
		.prog_data		(prog_data)
	);

	////////////////////
	// Filter CPU
	////////////////////
	sc_cpu sc_cpu_i
	(
		.AUD_CTRL_CLK	(AUD_CTRL_CLK),
		.reset			(reset),
		.link			(link_i.cpu),
		.bus			(bus_i.cpu)
	);

endmodule

// File: bench/tb_clock.sv
/*
 * Testbench clock and reset generator
 * 4 ns AUD_CTRL_CLK, reset held high for 8 cycles
 */
`timescale 1ns/1ps

module tb_clock
(
	output	logic	AUD_CTRL_CLK,
	output	logic	reset
);

	initial
	begin
		AUD_CTRL_CLK = 1'b0;
		forever #2 AUD_CTRL_CLK = ~AUD_CTRL_CLK;	// 250 MHz
	end

	initial
	begin
		reset = 1'b1;
		repeat (8) @(posedge AUD_CTRL_CLK);
		#1 reset = 1'b0;	// Released off the edge
	end

endmodule

// File: bench/dsp_core_properties.sv
/*
 * Handshake and memory write assertions
 * Bound into the CPU, watching req/ack and the RAM write enable
 */
`timescale 1ns/1ps
`include "dsp_settings.svh"

module dsp_core_properties
(
	input	logic					AUD_CTRL_CLK,
	input	logic					reset,
	input	logic					req,
	input	logic					ack,
	input	logic					we,
	input	cpu_pkg::cpu_state_e	state
);

	////////////////////
	// Four-phase handshake
	////////////////////
	req_holds: assert property (@(posedge AUD_CTRL_CLK) disable iff (reset)
		req && !ack |=> req)
		else $error("req dropped before ack");

	ack_needs_req: assert property (@(posedge AUD_CTRL_CLK) disable iff (reset)
		$rose(ack) |-> req)
		else $error("ack rose while req was low");

	// Phase 4 only once req is gone
	ack_falls_late: assert property (@(posedge AUD_CTRL_CLK) disable iff (reset)
		$fell(ack) |-> !req && !$past(req))
		else $error("ack fell while req was still high");

	////////////////////
	// RAM write
	////////////////////
	// No run in flight means the FSM waits in IDLE without writing
	idle_no_write: assert property (@(posedge AUD_CTRL_CLK) disable iff (reset)
		!req && !ack |-> state == cpu_pkg::S_IDLE && !we)
		else $error("CPU busy or writing RAM with no run in flight");

endmodule

// File: bench/dsp_core_tb.sv
/*
 * Directed testbench of the audio DSP core
 * Program loader, frame driver, value checker, reference models, timeout
 */
`timescale 1ns/1ps
`include "dsp_settings.svh"

module dsp_core_tb;

	localparam int FRAME_CYCLES	= 80;	// Edge spacing
	localparam int HIGH_CYCLES	= 40;	// LR clock high part of a frame
	localparam int MAX_FRAMES	= 75;	// Tests use about 32 frames plus loads
	localparam int CYCLE_LIMIT	= MAX_FRAMES * FRAME_CYCLES;

	logic AUD_CTRL_CLK;
	logic reset;
	logic dac_lrck;
	audio_pkg::audio_sample_t adc_sample;
	logic prog_we;
	cpu_pkg::mem_addr_t prog_addr;
	cpu_pkg::cpu_word_t prog_data;
	audio_pkg::audio_sample_t audio_out;

	int unsigned cycles = 0;
	audio_pkg::audio_sample_t pending;	// Output due at the next edge

	tb_clock tb_clock_i
	(
		.AUD_CTRL_CLK	(AUD_CTRL_CLK),
		.reset			(reset)
	);

	dsp_core_top dsp_core_top_i
	(
		.AUD_CTRL_CLK	(AUD_CTRL_CLK),
		.reset			(reset),
		.dac_lrck		(dac_lrck),
		.adc_sample		(adc_sample),
		.prog_we		(prog_we),
		.prog_addr		(prog_addr),
		.prog_data		(prog_data),
		.audio_out		(audio_out)
	);

	bind sc_cpu dsp_core_properties dsp_core_properties_i
	(
		.AUD_CTRL_CLK	(AUD_CTRL_CLK),
		.reset			(reset),
		.req			(link.req),
		.ack			(link.ack),
		.we				(bus.we),
		.state			(state)
	);

	// Run limit
	always @(posedge AUD_CTRL_CLK)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout: simulation passed %0d cycles without finishing", CYCLE_LIMIT);
			$display("Result: FAILED");
			$fatal(1, "Timeout");
		end
	end

	////////////////////
	// Helpers
	////////////////////
	task automatic next_cycle;
		@(posedge AUD_CTRL_CLK);
		#1;	// Drive point
	endtask

	task automatic check_value(input string name, input logic [`DSP_SAMPLE_W-1:0] expected,
		input logic [`DSP_SAMPLE_W-1:0] actual);
		if (actual !== expected)
		begin
			$display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
			$display("Result: FAILED");
			$fatal(1, "Value mismatch");
		end
	endtask

	// Opcode above a 12-bit field
	function automatic cpu_pkg::cpu_word_t instr(input cpu_pkg::cpu_opcode_e op,
		input int unsigned field);
		instr = {op, cpu_pkg::cpu_addr_t'(field)};
	endfunction

	function automatic audio_pkg::audio_word_t widen(input audio_pkg::audio_sample_t s);
		widen = {s, 2'b00};	// Two zero bits below
	endfunction

	function automatic audio_pkg::audio_sample_t to_out(input audio_pkg::audio_word_t w);
		to_out = w[17:2];	// Upper 16 bits
	endfunction

	// 2.16 multiply, sign plus product bits 32..16
	function automatic audio_pkg::audio_word_t gain_model(input audio_pkg::audio_word_t x,
		input audio_pkg::audio_word_t c);
		logic signed [35:0] p;
		p = x * c;
		gain_model = {p[35], p[32:16]};
	endfunction

	task automatic load_word(input int unsigned addr, input cpu_pkg::cpu_word_t data);
		prog_we		= 1'b1;
		prog_addr	= cpu_pkg::mem_addr_t'(addr);
		prog_data	= data;
		next_cycle();
		prog_we		= 1'b0;
	endtask

	// Until req and ack are both low
	task automatic wait_idle;
		while (dsp_core_top_i.link_i.req || dsp_core_top_i.link_i.ack)
			next_cycle();
	endtask

	// One LR clock period, rise on the first edge
	task automatic frame(input audio_pkg::audio_sample_t s);
		dac_lrck	= 1'b1;
		adc_sample	= s;
		repeat (HIGH_CYCLES) next_cycle();
		dac_lrck	= 1'b0;
		repeat (FRAME_CYCLES - HIGH_CYCLES) next_cycle();
	endtask

	task automatic frame_and_check(input audio_pkg::audio_sample_t s,
		input audio_pkg::audio_sample_t result);
		frame(s);
		check_value("audio_out", pending, audio_out);
		pending = result;	// Shows at the next edge
	endtask

	////////////////////
	// Tests
	////////////////////
	task automatic reset_and_first_edge;
		audio_pkg::audio_sample_t s;
		check_value("audio_out", '0, audio_out);
		load_word(0, instr(cpu_pkg::OP_IN, 0));
		load_word(1, instr(cpu_pkg::OP_OUT, 0));
		s = audio_pkg::audio_sample_t'($urandom);
		frame_and_check(s, s);	// Still zero after it
	endtask

	task automatic passthrough;
		audio_pkg::audio_sample_t s;
		for (int i = 0; i < 6; i++)
		begin
			s = audio_pkg::audio_sample_t'($urandom);
			frame_and_check(s, s);
		end
	endtask

	task automatic add_store_load;
		audio_pkg::audio_sample_t s;
		audio_pkg::audio_word_t k;
		logic [`DSP_WORD_W-1:0] sum;
		k = audio_pkg::audio_word_t'($urandom);
		wait_idle();
		load_word(0, instr(cpu_pkg::OP_IN, 0));
		load_word(1, instr(cpu_pkg::OP_ADD, 16));
		load_word(2, instr(cpu_pkg::OP_ST, 17));
		load_word(3, instr(cpu_pkg::OP_LD, 17));
		load_word(4, instr(cpu_pkg::OP_OUT, 0));
		load_word(16, k);
		for (int i = 0; i < 6; i++)
		begin
			s = audio_pkg::audio_sample_t'($urandom);
			sum = widen(s) + k;	// 18-bit wrap
			frame_and_check(s, to_out(sum));
		end
	endtask

	task automatic gain;
		audio_pkg::audio_sample_t s;
		audio_pkg::audio_word_t c;
		c = audio_pkg::audio_word_t'($urandom);
		wait_idle();
		load_word(0, instr(cpu_pkg::OP_IN, 0));
		load_word(1, instr(cpu_pkg::OP_MULT, 16));
		load_word(2, instr(cpu_pkg::OP_OUT, 0));
		load_word(16, c);
		for (int i = 0; i < 6; i++)
		begin
			s = audio_pkg::audio_sample_t'($urandom);
			frame_and_check(s, to_out(gain_model(widen(s), c)));
		end
	endtask

	task automatic branch_shift;
		audio_pkg::audio_sample_t s;
		logic [`DSP_WORD_W-1:0] w;
		wait_idle();
		load_word(0, instr(cpu_pkg::OP_IN, 0));
		load_word(1, instr(cpu_pkg::OP_JNEG, 3));	// Negative skips the shift
		load_word(2, instr(cpu_pkg::OP_SHL, 16));
		load_word(3, instr(cpu_pkg::OP_OUT, 0));
		load_word(16, 18'd1);
		for (int i = 0; i < 8; i++)
		begin
			s = audio_pkg::audio_sample_t'($urandom);
			s[`DSP_SAMPLE_W-1] = i[0];	// Both signs in turn
			w = widen(s);
			if (!w[`DSP_WORD_W-1])
				w = w << 1;
			frame_and_check(s, to_out(w));
		end
	endtask

	// Run of about 140 cycles, past the next edge
	task automatic skip_when_busy;
		audio_pkg::audio_sample_t sa, sb, sc, sd;
		audio_pkg::audio_sample_t held;
		sa = audio_pkg::audio_sample_t'($urandom);
		sb = ~sa;
		sc = audio_pkg::audio_sample_t'($urandom);
		sd = ~sc;
		wait_idle();
		load_word(0, instr(cpu_pkg::OP_IN, 0));
		load_word(1, instr(cpu_pkg::OP_ST, 20));	// Save sample
		load_word(2, instr(cpu_pkg::OP_LD, 16));
		load_word(3, instr(cpu_pkg::OP_ADD, 17));	// Count up to zero
		load_word(4, instr(cpu_pkg::OP_JNEG, 3));
		load_word(5, instr(cpu_pkg::OP_LD, 20));
		load_word(6, instr(cpu_pkg::OP_OUT, 0));
		load_word(16, -18'sd20);
		load_word(17, 18'd1);
		held = pending;
		frame_and_check(sa, sa);
		frame(sb);	// Run of sa still busy
		check_value("audio_out", held, audio_out);
		frame(sc);
		check_value("audio_out", sa, audio_out);	// sb never shows
		frame(sd);
		check_value("audio_out", sa, audio_out);
		wait_idle();
		pending = sc;
		frame_and_check(sd, sd);	// sc shows once its run is done
	endtask

	initial
	begin
		dac_lrck	= 1'b0;
		adc_sample	= '0;
		prog_we		= 1'b0;
		prog_addr	= '0;
		prog_data	= '0;
		pending		= '0;	// Result register clears on reset
		void'($urandom(32'hf92e19e0));
		@(negedge reset);
		next_cycle();
		reset_and_first_edge();
		passthrough();
		add_store_load();
		gain();
		branch_shift();
		skip_when_busy();
		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: list.f
+incdir+src
src/audio_pkg.sv
src/cpu_pkg.sv
src/sample_if.sv
src/mem_if.sv
src/sample_framer.sv
src/sc_memory.sv
src/sc_cpu.sv
src/dsp_core_top.sv
bench/tb_clock.sv
bench/dsp_core_properties.sv
bench/dsp_core_tb.sv

// File: Bender.yml
package:
  name: dsp_core

sources:
  - include_dirs:
      - src
    files:
      - src/audio_pkg.sv
      - src/cpu_pkg.sv
      - src/sample_if.sv
      - src/mem_if.sv
      - src/sample_framer.sv
      - src/sc_memory.sv
      - src/sc_cpu.sv
      - src/dsp_core_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/tb_clock.sv
      - bench/dsp_core_properties.sv
      - bench/dsp_core_tb.sv
